/* all.f */
common/dbg_wb_pkg.sv
verilog/dbg_crc32.sv
verilog/dbg_wb_biu.sv
dbg_wb/dbg_wb_ctrl.sv
dbg_wb/dbg_wb_datapath.sv
dbg_wb/dbg_wb_top.sv
dv/dbg_wb_biu_checker.sv
dv/dbg_wb_tb.sv

/* dv/dbg_wb_tb.sv */
// Wishbone debug module testbench
`timescale 1ns/1ps

module dbg_wb_tb
  import dbg_wb_pkg::*;
;

  localparam int BURST_RUNS = 6;      // Two empty, two write, two read
  localparam int POLL_MAX   = 64;     // Ready bit polls before giving up

  logic              tck_i;
  logic              rst_i;
  logic              tdi_i;
  logic              capture_dr_i;
  logic              shift_dr_i;
  logic              update_dr_i;
  logic              module_select_i;
  logic [DR_W-1:0]   data_register_i;
  logic              module_tdo_o;
  logic              top_inhibit_o;
  logic [31:0]       wb_adr_o;
  logic [WORD_W-1:0] wb_dat_o;
  logic [3:0]        wb_sel_o;
  logic              wb_we_o;
  logic              wb_cyc_o;
  logic              wb_stb_o;
  logic [WORD_W-1:0] wb_dat_i;
  logic              wb_ack_i;
  logic              wb_err_i;

  logic [31:0] mem [0:255];      // Slave memory, word indexed
  logic [31:0] words [0:7];      // Burst payload
  logic [31:0] exp_adr_q [$];    // Expected bus transfers in order
  logic        exp_we_q [$];
  logic [31:0] exp_dat_q [$];
  int          ack_wait = 0;
  int          xfer_count = 0;
  int          checks = 0;
  int          errors = 0;
  int          xfer_before;

  dbg_wb_top #(
    .CNT_W(16)
  ) uut (.*);

  initial begin
    tck_i = 1'b0;
    forever #2 tck_i = ~tck_i;  // 4 ns period
  end

  ////////////////////
  // Reference and compare
  ////////////////////

  // One word into the CRC, LSB first
  function automatic logic [31:0] crc32_ref(input logic [31:0] crc_in, input logic [31:0] word);
    logic [31:0] crc;
    logic        fb;
    int          i;
    crc = crc_in;
    for (i = 0; i < 32; i++) begin
      fb  = crc[0] ^ word[i];
      crc = crc >> 1;
      if (fb) crc = crc ^ 32'hEDB88320;
    end
    return crc;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Wishbone slave model
  ////////////////////

  task automatic serve_cycle();
    logic [31:0] exp_adr;
    logic        exp_we;
    logic [31:0] exp_dat;
    xfer_count++;
    assert (exp_adr_q.size() != 0) else begin
      errors++;
      $display("Unexpected Wishbone cycle at %0t ns, address %h", $time, wb_adr_o);
    end
    if (exp_adr_q.size() != 0) begin
      exp_adr = exp_adr_q.pop_front();
      exp_we  = exp_we_q.pop_front();
      exp_dat = exp_dat_q.pop_front();
      check_val("wb_adr_o", wb_adr_o, exp_adr);
      check_val("wb_we_o", 32'(wb_we_o), 32'(exp_we));
      check_val("wb_sel_o", 32'(wb_sel_o), 32'hf);
      if (exp_we) check_val("wb_dat_o", wb_dat_o, exp_dat);
    end
    if (wb_we_o) begin
      mem[wb_adr_o[9:2]] = wb_dat_o;
    end else begin
      wb_dat_i = mem[wb_adr_o[9:2]];
    end
  endtask

  // Ack after 0 to 3 wait cycles
  always @(posedge tck_i) begin
    #1;
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;             // Single-cycle ack
    end else if (wb_cyc_o && wb_stb_o) begin
      if (ack_wait != 0) begin
        ack_wait--;
      end else begin
        serve_cycle();
        wb_ack_i = 1'b1;
        ack_wait = $urandom_range(3, 0);
      end
    end
  end

  ////////////////////
  // TAP model
  ////////////////////

  // One shift cycle, TDO taken mid-cycle
  task automatic shift_bit(input logic din, output logic dout);
    tdi_i      = din;
    shift_dr_i = 1'b1;
    @(negedge tck_i);
    dout = module_tdo_o;
    @(posedge tck_i);
    #1;
    data_register_i = {din, data_register_i[DR_W-1:1]};  // DR shifts right
    shift_dr_i      = 1'b0;
  endtask

  task automatic capture_pulse();
    @(posedge tck_i);       // Select-DR-Scan before Capture-DR
    #1;
    capture_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    capture_dr_i    = 1'b0;
    data_register_i = '0;   // Capture leaves no start bit
  endtask

  task automatic update_pulse();
    update_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    update_dr_i = 1'b0;
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic [31:0] addr, input logic [15:0] cnt);
    logic [DR_W-1:0] cmd;
    logic            dummy;
    int              i;
    cmd = {1'b0, op, addr, cnt};
    capture_pulse();
    for (i = 0; i < DR_W; i++) shift_bit(cmd[i], dummy);
    update_pulse();
  endtask

  task automatic wait_bus_idle();
    int n;
    n = 0;
    while ((exp_adr_q.size() != 0 || wb_cyc_o) && n < 100) begin
      @(posedge tck_i);
      #1;
      n++;
    end
    assert (n < 100) else begin
      errors++;
      $display("Expected Wishbone transfers still missing after 100 cycles");
    end
  endtask

  ////////////////////
  // Bursts
  ////////////////////

  task automatic write_burst(input logic [31:0] addr, input int n, input bit bad_crc);
    logic [31:0] crc;
    logic [31:0] crc_tx;
    logic [31:0] a;
    logic        dummy;
    logic        match;
    int          k;
    int          b;
    crc = '1;
    for (k = 0; k < n; k++) begin
      words[k] = $urandom;
      crc      = crc32_ref(crc, words[k]);
      exp_adr_q.push_back(addr + 32'(4 * k));
      exp_we_q.push_back(1'b1);
      exp_dat_q.push_back(words[k]);
    end
    crc_tx = bad_crc ? (crc ^ 32'h0000_0100) : crc;  // One bit flipped
    send_cmd(CMD_BWRITE32, addr, 16'(n));
    capture_pulse();
    shift_bit(1'b1, dummy);                          // Start bit
    for (k = 0; k < n; k++) begin
      for (b = 0; b < 32; b++) shift_bit(words[k][b], dummy);
    end
    for (b = 0; b < 32; b++) shift_bit(crc_tx[b], dummy);
    @(negedge tck_i);
    match = module_tdo_o;
    check_val("match bit", 32'(match), 32'(!bad_crc));
    check_val("top_inhibit_o", 32'(top_inhibit_o), 32'd1);
    @(posedge tck_i);
    #1;
    update_pulse();
    check_val("top_inhibit_o", 32'(top_inhibit_o), 32'd0);
    wait_bus_idle();
    for (k = 0; k < n; k++) begin
      a = addr + 32'(4 * k);
      check_val("memory word", mem[a[9:2]], words[k]);
    end
  endtask

  task automatic read_burst(input logic [31:0] addr, input int n);
    logic [31:0] crc;
    logic [31:0] got;
    logic [31:0] a;
    logic        tdo;
    int          k;
    int          b;
    int          polls;
    crc = '1;
    for (k = 0; k < n; k++) begin
      a              = addr + 32'(4 * k);
      words[k]       = $urandom;
      mem[a[9:2]]    = words[k];                     // Preload
      crc            = crc32_ref(crc, words[k]);
      exp_adr_q.push_back(a);
      exp_we_q.push_back(1'b0);
      exp_dat_q.push_back(32'h0);
    end
    send_cmd(CMD_BREAD32, addr, 16'(n));
    capture_pulse();
    tdo   = 1'b0;
    polls = 0;
    while (!tdo && polls < POLL_MAX) begin            // Poll ready bit
      shift_bit(1'b0, tdo);
      polls++;
    end
    assert (tdo) else begin
      errors++;
      $display("Read ready bit never went high after %0d polls", POLL_MAX);
    end
    check_val("top_inhibit_o", 32'(top_inhibit_o), 32'd1);
    for (k = 0; k < n; k++) begin
      for (b = 0; b < 32; b++) begin
        shift_bit(1'b0, tdo);
        got[b] = tdo;
      end
      check_val("read word", got, words[k]);
    end
    for (b = 0; b < 32; b++) begin                    // CRC follows data
      shift_bit(1'b0, tdo);
      got[b] = tdo;
    end
    check_val("read crc", got, crc);
    check_val("top_inhibit_o", 32'(top_inhibit_o), 32'd1);
    update_pulse();
    check_val("top_inhibit_o", 32'(top_inhibit_o), 32'd0);
    wait_bus_idle();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h6c4f));
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b0;
    data_register_i = '0;
    wb_dat_i        = '0;
    wb_ack_i        = 1'b0;
    wb_err_i        = 1'b0;
    repeat (16) @(posedge tck_i);
    #1;
    rst_i           = 1'b0;
    module_select_i = 1'b1;
    @(posedge tck_i);
    #1;
    check_val("top_inhibit_o", 32'(top_inhibit_o), 32'd0);
    check_val("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
    check_val("module_tdo_o", 32'(module_tdo_o), 32'd1);  // Bus ready

    // Empty bursts start no bus cycle
    xfer_before = xfer_count;
    send_cmd(CMD_BWRITE32, 32'h0000_0100, 16'd0);
    capture_pulse();
    update_pulse();
    send_cmd(CMD_BREAD32, 32'h0000_0200, 16'd0);
    capture_pulse();
    update_pulse();
    repeat (8) @(posedge tck_i);
    #1;
    check_val("bus transfer count", 32'(xfer_count), 32'(xfer_before));
    check_val("wb_cyc_o", 32'(wb_cyc_o), 32'd0);

    write_burst($urandom & 32'hFFFF_FFFC, $urandom_range(8, 1), 1'b0);
    write_burst($urandom & 32'hFFFF_FFFC, $urandom_range(8, 1), 1'b1);
    read_burst($urandom & 32'hFFFF_FFFC, $urandom_range(8, 1));
    read_burst($urandom & 32'hFFFF_FFFC, $urandom_range(8, 1));

    $display("Closing counts: %0d checks, %0d compare errors, %0d protocol errors",
             checks, errors, uut.u_biu.u_checker.err_cnt);
    if (errors == 0 && uut.u_biu.u_checker.err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized by the number of bursts
  initial begin
    repeat (BURST_RUNS * 2000) @(posedge tck_i);
    $display("Timeout after %0d cycles, the burst sequence did not finish", BURST_RUNS * 2000);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* dv/dbg_wb_biu_checker.sv */
// Bus unit protocol checker
`timescale 1ns/1ps

module dbg_wb_biu_checker (
  input logic        tck_i,
  input logic        rst_i,
  input logic        strobe_i,
  input logic        rdy_o,
  input logic        wb_cyc_o,
  input logic        wb_stb_o,
  input logic        wb_we_o,
  input logic [31:0] wb_adr_o,
  input logic        wb_ack_i,
  input logic        wb_err_i
);

  int err_cnt = 0;  // Failed assertions so far

  // Classic cycle, stb never alone
  stb_needs_cyc: assert property (@(posedge tck_i) disable iff (rst_i)
    wb_stb_o |-> wb_cyc_o)
    else begin
      err_cnt++;
      $error("wb_stb_o high while wb_cyc_o low");
    end

  // Request held until the slave ends the cycle
  stb_held: assert property (@(posedge tck_i) disable iff (rst_i)
    wb_stb_o && !(wb_ack_i || wb_err_i) |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o))
    else begin
      err_cnt++;
      $error("wb_stb_o, wb_adr_o or wb_we_o changed before ack");
    end

  // A strobe while busy would be dropped
  strobe_when_ready: assert property (@(posedge tck_i) disable iff (rst_i)
    strobe_i |-> rdy_o)
    else begin
      err_cnt++;
      $error("Transfer strobe while the bus unit is busy");
    end

endmodule

bind dbg_wb_biu dbg_wb_biu_checker u_checker (.*);

/* dbg_wb/dbg_wb_top.sv */
// Wishbone debug module top
`timescale 1ns/1ps

module dbg_wb_top
  import dbg_wb_pkg::*;
#(
  parameter int CNT_W = 16  // Word count width
) (
  input  logic              tck_i,
  input  logic              rst_i,
  // TAP side
  input  logic              tdi_i,
  input  logic              capture_dr_i,
  input  logic              shift_dr_i,
  input  logic              update_dr_i,
  input  logic              module_select_i,
  input  logic [DR_W-1:0]   data_register_i,
  output logic              module_tdo_o,
  output logic              top_inhibit_o,
  // Wishbone master
  output logic [31:0]       wb_adr_o,
  output logic [WORD_W-1:0] wb_dat_o,
  output logic [3:0]        wb_sel_o,
  output logic              wb_we_o,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  input  logic [WORD_W-1:0] wb_dat_i,
  input  logic              wb_ack_i,
  input  logic              wb_err_i
);

  ////////////////////
  // Internal wires
  ////////////////////

  dp_ctrl_t          dp_ctrl;
  crc_ctrl_t         crc_ctrl;
  biu_req_t          biu_req;
  logic              biu_strobe;
  logic              biu_rdy;
  logic [WORD_W-1:0] biu_rdata;
  logic              word_zero;
  logic              word_last;
  logic              bit_max;
  logic              bit_32;
  logic              crc_data;   // Bit fed to the CRC
  logic              crc_serial;
  logic              crc_match;

  dbg_wb_ctrl u_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .module_select_i(module_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .cmd_i          (data_register_i[CMD_BIT:OP_LSB]),  // Command/start bit and opcode
    .word_zero_i    (word_zero),
    .word_last_i    (word_last),
    .bit_max_i      (bit_max),
    .bit_32_i       (bit_32),
    .biu_rdy_i      (biu_rdy),
    .dp_ctrl_o      (dp_ctrl),
    .crc_ctrl_o     (crc_ctrl),
    .biu_strobe_o   (biu_strobe),
    .top_inhibit_o  (top_inhibit_o)
  );

  dbg_wb_datapath #(
    .CNT_W(CNT_W)
  ) u_datapath (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .data_register_i(data_register_i),
    .dp_ctrl_i      (dp_ctrl),
    .biu_rdata_i    (biu_rdata),
    .biu_rdy_i      (biu_rdy),
    .crc_match_i    (crc_match),
    .crc_serial_i   (crc_serial),
    .biu_req_o      (biu_req),
    .word_zero_o    (word_zero),
    .word_last_o    (word_last),
    .bit_max_o      (bit_max),
    .bit_32_o       (bit_32),
    .tdo_o          (module_tdo_o),
    .rd_o           (),             // Flag travels inside biu_req
    .crc_data_o     (crc_data)
  );

  dbg_crc32 u_crc (
    .tck_i     (tck_i),
    .rst_i     (rst_i),
    .data_i    (crc_data),
    .crc_ctrl_i(crc_ctrl),
    .cmp_i     (data_register_i[CMD_BIT -: WORD_W]),  // CRC word sent by host
    .serial_o  (crc_serial),
    .match_o   (crc_match)
  );

  dbg_wb_biu u_biu (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .strobe_i(biu_strobe),
    .req_i   (biu_req),
    .wb_dat_i(wb_dat_i),
    .wb_ack_i(wb_ack_i),
    .wb_err_i(wb_err_i),
    .rdy_o   (biu_rdy),
    .rdata_o (biu_rdata),
    .wb_adr_o(wb_adr_o),
    .wb_dat_o(wb_dat_o),
    .wb_sel_o(wb_sel_o),
    .wb_we_o (wb_we_o),
    .wb_cyc_o(wb_cyc_o),
    .wb_stb_o(wb_stb_o)
  );

endmodule

/* dbg_wb/dbg_wb_datapath.sv */
// Burst counters and TDO datapath
`timescale 1ns/1ps

module dbg_wb_datapath
  import dbg_wb_pkg::*;
#(
  parameter int CNT_W = 16  // Word count width
) (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              tdi_i,
  input  logic [DR_W-1:0]   data_register_i,
  input  dp_ctrl_t          dp_ctrl_i,
  input  logic [WORD_W-1:0] biu_rdata_i,
  input  logic              biu_rdy_i,
  input  logic              crc_match_i,
  input  logic              crc_serial_i,
  output biu_req_t          biu_req_o,
  output logic              word_zero_o,
  output logic              word_last_o,
  output logic              bit_max_o,
  output logic              bit_32_o,
  output logic              tdo_o,
  output logic              rd_o,
  output logic              crc_data_o
);

  localparam int RD_BIT = OP_LSB + 2;  // Opcode bit 2 marks a read

  logic [31:0]       addr_q;     // Next bus address
  logic [CNT_W-1:0]  word_cnt_q; // Words left
  logic [5:0]        bit_cnt_q;
  logic              rd_q;
  logic [WORD_W-1:0] out_sr_q;   // Read word, LSB first

  ////////////////////
  // Counters
  ////////////////////

  always_ff @(posedge tck_i) begin
    if (dp_ctrl_i.addr_load) begin
      addr_q <= data_register_i[ADDR_MSB:ADDR_LSB];
    end else if (dp_ctrl_i.addr_inc) begin
      addr_q <= addr_q + 32'(WORD_BYTES);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      word_cnt_q <= '0;
    end else if (dp_ctrl_i.word_load) begin
      word_cnt_q <= data_register_i[CNT_MSB -: CNT_W];
    end else if (dp_ctrl_i.word_dec) begin
      word_cnt_q <= word_cnt_q - CNT_W'(1);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (dp_ctrl_i.bit_clr) begin  // Clear wins at word end
      bit_cnt_q <= '0;
    end else if (dp_ctrl_i.bit_inc) begin
      bit_cnt_q <= bit_cnt_q + 6'd1;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rd_q <= 1'b0;
    end else if (dp_ctrl_i.op_load) begin
      rd_q <= data_register_i[RD_BIT];
    end
  end

  assign word_zero_o = (word_cnt_q == '0);
  assign word_last_o = (word_cnt_q == CNT_W'(1));
  assign bit_max_o   = (bit_cnt_q == 6'd31);
  assign bit_32_o    = (bit_cnt_q == 6'd32);   // Full CRC word received
  assign rd_o        = rd_q;

  ////////////////////
  // Read shift and TDO
  ////////////////////

  always_ff @(posedge tck_i) begin
    if (dp_ctrl_i.out_load) begin
      out_sr_q <= biu_rdata_i;
    end else if (dp_ctrl_i.out_shift) begin
      out_sr_q <= {1'b0, out_sr_q[WORD_W-1:1]};
    end
  end

  // Reads hash outgoing bits, writes hash TDI
  assign crc_data_o = rd_q ? out_sr_q[0] : tdi_i;

  always_comb begin
    case (dp_ctrl_i.tdo_sel)
      TDO_READY: tdo_o = biu_rdy_i;
      TDO_DATA:  tdo_o = out_sr_q[0];
      TDO_MATCH: tdo_o = crc_match_i;
      default:   tdo_o = crc_serial_i;
    endcase
  end

  // Write word completes as its last bit sits on TDI
  assign biu_req_o.addr  = addr_q;
  assign biu_req_o.wdata = {tdi_i, data_register_i[CMD_BIT:CMD_BIT-WORD_W+2]};
  assign biu_req_o.rd    = rd_q;

endmodule

/* dbg_wb/dbg_wb_ctrl.sv */
// Burst control FSM
`timescale 1ns/1ps

module dbg_wb_ctrl
  import dbg_wb_pkg::*;
(
  input  logic                  tck_i,
  input  logic                  rst_i,
  input  logic                  module_select_i,
  input  logic                  capture_dr_i,
  input  logic                  shift_dr_i,
  input  logic                  update_dr_i,
  input  logic [CMD_BIT-OP_LSB:0] cmd_i,       // {command bit, opcode}
  input  logic                  word_zero_i,
  input  logic                  word_last_i,
  input  logic                  bit_max_i,
  input  logic                  bit_32_i,
  input  logic                  biu_rdy_i,
  output dp_ctrl_t              dp_ctrl_o,
  output crc_ctrl_t             crc_ctrl_o,
  output logic                  biu_strobe_o,
  output logic                  top_inhibit_o
);

  localparam int SEL_POS = CMD_BIT - OP_LSB;  // Command bit inside cmd_i

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic [3:0]  op_field;
  logic        for_module;  // Selected and command bit clear
  logic        start_bit;
  logic        cmd_wr;
  logic        cmd_rd;
  logic        rd_go;       // Ready bit seen by host
  logic        rd_wrap;     // Last bit of a read word
  logic        rd_next;     // Load next read word
  logic        wr_wrap;     // Last bit of a write word

  ////////////////////
  // Command decode
  ////////////////////

  assign op_field   = cmd_i[OP_MSB-OP_LSB:0];
  assign for_module = module_select_i & ~cmd_i[SEL_POS];
  assign start_bit  = module_select_i & cmd_i[SEL_POS];  // Same bit, set by host after capture
  assign cmd_wr     = update_dr_i & for_module & (op_field == CMD_BWRITE32);
  assign cmd_rd     = update_dr_i & for_module & (op_field == CMD_BREAD32);

  assign rd_go   = (state_q == ST_RSTATUS) & biu_rdy_i & shift_dr_i;
  assign rd_wrap = (state_q == ST_RBURST) & shift_dr_i & bit_max_i;
  assign rd_next = rd_go | (rd_wrap & ~word_zero_i);
  assign wr_wrap = (state_q == ST_WBURST) & shift_dr_i & bit_max_i;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_rd) begin
          state_d = ST_RBEGIN;
        end else if (cmd_wr) begin
          state_d = ST_WREADY;
        end
      end
      ST_RBEGIN:  state_d = word_zero_i ? ST_IDLE : ST_RREADY;  // Empty read burst
      ST_RREADY:  if (module_select_i && capture_dr_i) state_d = ST_RSTATUS;
      ST_RSTATUS: if (rd_go) state_d = ST_RBURST;
      ST_RBURST:  if (rd_wrap && word_zero_i) state_d = ST_RCRC;
      ST_RCRC:    state_d = ST_RCRC;                              // Held until update_dr
      ST_WREADY: begin
        if (word_zero_i) begin
          state_d = ST_IDLE;                                      // Empty write burst
        end else if (module_select_i && capture_dr_i) begin
          state_d = ST_WWAIT;
        end
      end
      ST_WWAIT:   if (start_bit && shift_dr_i) state_d = ST_WBURST;
      ST_WBURST:  if (wr_wrap && word_zero_i) state_d = ST_WCRC;
      ST_WCRC:    if (bit_32_i) state_d = ST_WMATCH;              // Host CRC now in DR
      ST_WMATCH:  state_d = ST_WMATCH;
      default:    state_d = ST_IDLE;
    endcase
    // Host may end any burst early
    if (update_dr_i && (state_q != ST_IDLE)) begin
      state_d = ST_IDLE;
    end
  end

  ////////////////////
  // Enables
  ////////////////////

  always_comb begin
    dp_ctrl_o         = '0;
    dp_ctrl_o.tdo_sel = TDO_READY;  // Idle shows bus ready
    crc_ctrl_o        = '0;
    biu_strobe_o      = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (cmd_wr || cmd_rd) begin
          dp_ctrl_o.addr_load = 1'b1;
          dp_ctrl_o.op_load   = 1'b1;
          dp_ctrl_o.bit_clr   = 1'b1;
          dp_ctrl_o.word_load = 1'b1;
          crc_ctrl_o.clr      = 1'b1;
        end
      end
      ST_RBEGIN: begin
        biu_strobe_o       = ~word_zero_i;  // First read goes out early
        dp_ctrl_o.addr_inc = ~word_zero_i;
      end
      ST_RBURST: begin
        dp_ctrl_o.tdo_sel   = TDO_DATA;
        dp_ctrl_o.out_shift = shift_dr_i;
        dp_ctrl_o.bit_inc   = shift_dr_i;
        crc_ctrl_o.en       = shift_dr_i;   // Outgoing bit into CRC
      end
      ST_RCRC: begin
        dp_ctrl_o.tdo_sel = TDO_CRC;
        crc_ctrl_o.shift  = shift_dr_i;
      end
      ST_WWAIT: begin
        if (start_bit && shift_dr_i) begin  // Bit 0 already on TDI
          dp_ctrl_o.bit_inc  = 1'b1;
          dp_ctrl_o.word_dec = 1'b1;
          crc_ctrl_o.en      = 1'b1;
          crc_ctrl_o.in_sel  = 1'b1;
        end
      end
      ST_WBURST: begin
        dp_ctrl_o.bit_inc = shift_dr_i;
        crc_ctrl_o.en     = shift_dr_i;
        crc_ctrl_o.in_sel = 1'b1;
        if (wr_wrap) begin                  // Word complete on TDI
          biu_strobe_o       = 1'b1;
          dp_ctrl_o.addr_inc = 1'b1;
          dp_ctrl_o.bit_clr  = 1'b1;
          dp_ctrl_o.word_dec = ~word_zero_i;
        end
      end
      ST_WCRC: begin
        dp_ctrl_o.bit_inc = shift_dr_i;
        if (bit_32_i) dp_ctrl_o.tdo_sel = TDO_MATCH;
      end
      ST_WMATCH: dp_ctrl_o.tdo_sel = TDO_MATCH;
      default: ;
    endcase
    // Next read word, from ready poll or end of previous word
    if (rd_next) begin
      dp_ctrl_o.out_load = 1'b1;
      dp_ctrl_o.bit_clr  = 1'b1;
      dp_ctrl_o.word_dec = 1'b1;
      if (!word_last_i) begin
        biu_strobe_o       = 1'b1;
        dp_ctrl_o.addr_inc = 1'b1;
      end
    end
  end

  // Top level held off while host shifts burst data
  assign top_inhibit_o = state_q inside {ST_RSTATUS, ST_RBURST, ST_RCRC,
                                         ST_WWAIT, ST_WBURST, ST_WCRC, ST_WMATCH};

endmodule

/* verilog/dbg_wb_biu.sv */
// Wishbone bus interface unit
`timescale 1ns/1ps

module dbg_wb_biu
  import dbg_wb_pkg::*;
(
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              strobe_i,   // Start one transfer
  input  biu_req_t          req_i,
  input  logic [WORD_W-1:0] wb_dat_i,
  input  logic              wb_ack_i,
  input  logic              wb_err_i,
  output logic              rdy_o,
  output logic [WORD_W-1:0] rdata_o,
  output logic [31:0]       wb_adr_o,
  output logic [WORD_W-1:0] wb_dat_o,
  output logic [3:0]        wb_sel_o,
  output logic              wb_we_o,
  output logic              wb_cyc_o,
  output logic              wb_stb_o
);

  logic              cyc_q;    // Cycle open
  biu_req_t          req_q;    // Held for the whole cycle
  logic [WORD_W-1:0] rdata_q;
  logic              start;
  logic              done;

  assign start = strobe_i & ~cyc_q;              // Busy strobes dropped
  assign done  = cyc_q & (wb_ack_i | wb_err_i);  // Error ends cycle too

  ////////////////////
  // Cycle control
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      cyc_q <= 1'b0;
    end else if (start) begin
      cyc_q <= 1'b1;
    end else if (done) begin
      cyc_q <= 1'b0;
    end
  end

  // Request latch
  always_ff @(posedge tck_i) begin
    if (start) begin
      req_q <= req_i;
    end
  end

  // Read data capture on ack
  always_ff @(posedge tck_i) begin
    if (cyc_q && wb_ack_i && req_q.rd) begin
      rdata_q <= wb_dat_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign rdy_o    = ~cyc_q;  // Ready again the edge after ack
  assign rdata_o  = rdata_q;

  assign wb_adr_o = req_q.addr;
  assign wb_dat_o = req_q.wdata;
  assign wb_we_o  = ~req_q.rd;
  assign wb_sel_o = 4'hf;    // Full words only
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;   // Classic cycle, stb with cyc

endmodule

/* verilog/dbg_crc32.sv */
// Serial CRC-32
`timescale 1ns/1ps

module dbg_crc32
  import dbg_wb_pkg::*;
(
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              data_i,
  input  crc_ctrl_t         crc_ctrl_i,
  input  logic [WORD_W-1:0] cmp_i,     // Host CRC from DR
  output logic              serial_o,
  output logic              match_o
);

  localparam logic [31:0] CRC_POLY = 32'hEDB88320;  // Reflected polynomial

  logic [31:0] crc_q;
  logic        fb;

  assign fb = crc_q[0] ^ data_i;

  ////////////////////
  // CRC register
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (crc_ctrl_i.clr) begin
      crc_q <= '1;
    end else if (crc_ctrl_i.en) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? CRC_POLY : 32'h0);
    end else if (crc_ctrl_i.shift) begin
      crc_q <= {1'b0, crc_q[31:1]};  // Acts as its own output register
    end
  end

  // LSB first onto TDO, no final inversion
  assign serial_o = crc_q[0];
  assign match_o  = (cmp_i == crc_q);

endmodule

/* common/dbg_wb_pkg.sv */
// Wishbone debug module definitions
package dbg_wb_pkg;

  ////////////////////
  // Data register layout
  ////////////////////

  localparam logic [5:0] DR_W       = 6'd53;  // TAP data register length
  localparam int         CMD_BIT    = 52;     // 0 here addresses this module
  localparam int         OP_MSB     = 51;     // Opcode field
  localparam int         OP_LSB     = 48;
  localparam int         ADDR_MSB   = 47;     // Start address field
  localparam int         ADDR_LSB   = 16;
  localparam int         CNT_MSB    = 15;     // Top of word count field

  localparam int         WORD_W     = 32;     // Bus data width
  localparam int         WORD_BYTES = 4;      // Address step per word

  // Burst opcodes, all other codes ignored
  typedef enum logic [3:0] {
    CMD_BWRITE32 = 4'h3,
    CMD_BREAD32  = 4'h7
  } wb_op_e;

  // Burst controller states
  typedef enum logic [3:0] {
    ST_IDLE, ST_RBEGIN, ST_RREADY, ST_RSTATUS, ST_RBURST, ST_RCRC,
    ST_WREADY, ST_WWAIT, ST_WBURST, ST_WCRC, ST_WMATCH
  } ctrl_state_e;

  // TDO source select
  typedef enum logic [1:0] {
    TDO_READY = 2'd0,  // Bus ready bit
    TDO_DATA  = 2'd1,  // Output shift register LSB
    TDO_MATCH = 2'd2,  // CRC compare result
    TDO_CRC   = 2'd3   // CRC serial out
  } tdo_sel_e;

  // Controller enables into the datapath
  typedef struct packed {
    logic     addr_load;  // Take start address
    logic     addr_inc;   // Step by WORD_BYTES
    logic     op_load;    // Latch read/write flag
    logic     bit_clr;
    logic     bit_inc;
    logic     word_load;  // Take word count
    logic     word_dec;
    logic     out_load;   // Parallel load of read word
    logic     out_shift;
    tdo_sel_e tdo_sel;
  } dp_ctrl_t;

  // Controller enables into the CRC
  typedef struct packed {
    logic clr;     // Back to all ones
    logic en;      // One bit of CRC update
    logic in_sel;  // 1 for write data on TDI, 0 for read data
    logic shift;   // Serial output shift
  } crc_ctrl_t;

  // One bus transfer request
  typedef struct packed {
    logic [31:0]       addr;
    logic [WORD_W-1:0] wdata;
    logic              rd;
  } biu_req_t;

endpackage
